//--- logic/cpuPackage.sv
`default_nettype none

package cpuPackage;

	typedef logic [31:0] word;
	typedef logic [4:0] registerIndex;

	// Major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		opRegister = 7'b0110011,
		opImmediate = 7'b0010011,
		opLoad = 7'b0000011,
		opStore = 7'b0100011,
		opBranch = 7'b1100011,
		opJump = 7'b1101111
	} opcode;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt
	} aluOperation;

	// Operand source chosen for the execute stage
	typedef enum logic [1:0] {
		fromRegister = 2'b00,
		fromWriteback = 2'b01,
		fromMemoryStage = 2'b10
	} forwardSource;

	// funct3 and funct7 field codes
	localparam logic [2:0] funct3AddSub = 3'b000;
	localparam logic [2:0] funct3Slt = 3'b010;
	localparam logic [2:0] funct3Xor = 3'b100;
	localparam logic [2:0] funct3Or = 3'b110;
	localparam logic [2:0] funct3And = 3'b111;
	localparam logic [6:0] funct7Alternate = 7'b0100000;

	// addi x0, x0, 0
	localparam word nopInstruction = 32'h0000_0013;

endpackage

`default_nettype wire

//--- logic/instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
	input wire cpuPackage::word instruction,
	output cpuPackage::aluOperation aluOp,
	output cpuPackage::word immediate,
	output logic useImmediate,
	output logic readsSecond,
	output logic isLoad,
	output logic isStore,
	output logic isBranch,
	output logic isJump,
	output logic writesRegister
);

	cpuPackage::word immI, immS, immB, immJ;
	cpuPackage::aluOperation functionOp;
	logic hasDestination;
	logic isSubtract;

	assign immI = {{20{instruction[31]}}, instruction[31:20]};
	assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
	assign immB = {{20{instruction[31]}}, instruction[7], instruction[30:25],
		instruction[11:8], 1'b0};
	assign immJ = {{12{instruction[31]}}, instruction[19:12], instruction[20],
		instruction[30:21], 1'b0};

	// Writes to x0 are dropped here
	assign hasDestination = (instruction[11:7] != 5'd0);
	assign isSubtract = (instruction[31:25] == cpuPackage::funct7Alternate)
		&& (instruction[14:12] == cpuPackage::funct3AddSub);

	always_comb begin
		case (instruction[14:12])
			cpuPackage::funct3Slt: functionOp = cpuPackage::aluSlt;
			cpuPackage::funct3Xor: functionOp = cpuPackage::aluXor;
			cpuPackage::funct3Or: functionOp = cpuPackage::aluOr;
			cpuPackage::funct3And: functionOp = cpuPackage::aluAnd;
			default: functionOp = cpuPackage::aluAdd;
		endcase
	end

	always_comb begin
		aluOp = cpuPackage::aluAdd;
		immediate = immI;
		useImmediate = 1'b0;
		readsSecond = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		writesRegister = 1'b0;
		case (cpuPackage::opcode'(instruction[6:0]))
			cpuPackage::opRegister: begin
				readsSecond = 1'b1;
				writesRegister = hasDestination;
				aluOp = isSubtract ? cpuPackage::aluSub : functionOp;
			end
			cpuPackage::opImmediate: begin
				useImmediate = 1'b1;
				writesRegister = hasDestination;
				aluOp = functionOp;
			end
			cpuPackage::opLoad: begin
				useImmediate = 1'b1;
				isLoad = 1'b1;
				writesRegister = hasDestination;
			end
			cpuPackage::opStore: begin
				immediate = immS;
				useImmediate = 1'b1;
				readsSecond = 1'b1;
				isStore = 1'b1;
			end
			// beq compares by subtraction and the zero flag
			cpuPackage::opBranch: begin
				immediate = immB;
				readsSecond = 1'b1;
				isBranch = 1'b1;
				aluOp = cpuPackage::aluSub;
			end
			cpuPackage::opJump: begin
				immediate = immJ;
				isJump = 1'b1;
				writesRegister = hasDestination;
			end
			// Anything else passes through as a bubble
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input wire clock,
	input wire reset,
	input wire cpuPackage::registerIndex readIndexA,
	input wire cpuPackage::registerIndex readIndexB,
	input wire cpuPackage::registerIndex writeIndex,
	input wire writeEnable,
	input wire cpuPackage::word writeData,
	output cpuPackage::word readDataA,
	output cpuPackage::word readDataB
);

	// x0 has no storage
	cpuPackage::word registers [31:1];

	// A write in the same cycle is seen by the reader
	function automatic cpuPackage::word readPort(cpuPackage::registerIndex index);
		if (index == 5'd0) begin
			return '0;
		end else if (writeEnable && writeIndex == index) begin
			return writeData;
		end
		return registers[index];
	endfunction

	always_comb begin
		readDataA = readPort(readIndexA);
		readDataB = readPort(readIndexB);
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				registers[i] <= '0;
			end
		end else if (writeEnable && writeIndex != 5'd0) begin
			registers[writeIndex] <= writeData;
		end
	end

	assert property (@(posedge clock) disable iff (!reset)
		writeEnable |-> writeIndex != 5'd0)
		else $error("register write aimed at x0");

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input wire cpuPackage::registerIndex decodeSourceA,
	input wire cpuPackage::registerIndex decodeSourceB,
	input wire decodeReadsSecond,
	input wire decodeIsJump,
	input wire cpuPackage::registerIndex executeDestination,
	input wire executeIsLoad,
	input wire executeBranchTaken,
	input wire cpuPackage::registerIndex memoryDestination,
	input wire memoryWrites,
	input wire cpuPackage::registerIndex writebackDestination,
	input wire writebackWrites,
	output logic stall,
	output logic flushFetch,
	output logic flushDecode,
	output cpuPackage::forwardSource forwardA,
	output cpuPackage::forwardSource forwardB
);

	logic loadUse;

	// Chosen in decode and registered with the instruction, so the
	// producer now in execute sits in the memory stage one cycle later.
	// executeDestination is zero when that instruction writes nothing
	function automatic cpuPackage::forwardSource selectSource(cpuPackage::registerIndex source);
		if (source == 5'd0) begin
			return cpuPackage::fromRegister;
		end else if (executeDestination == source) begin
			return cpuPackage::fromMemoryStage;
		end else if (memoryWrites && memoryDestination == source) begin
			return cpuPackage::fromWriteback;
		end
		return cpuPackage::fromRegister;
	endfunction

	always_comb begin
		forwardA = selectSource(decodeSourceA);
		forwardB = selectSource(decodeSourceB);
	end

	assign loadUse = executeIsLoad && executeDestination != 5'd0
		&& (executeDestination == decodeSourceA
		|| (decodeReadsSecond && executeDestination == decodeSourceB));

	// A taken branch kills the waiting instruction anyway
	assign stall = loadUse && !executeBranchTaken;
	assign flushFetch = executeBranchTaken || (decodeIsJump && !stall);
	assign flushDecode = executeBranchTaken || stall;

	always_comb begin
		assert (!(executeIsLoad && executeBranchTaken))
			else $error("load and taken branch in execute together");
		assert (!(writebackWrites && writebackDestination == 5'd0))
			else $error("writeback targets x0");
	end

endmodule

`default_nettype wire

//--- logic/arithmeticUnit.sv
`timescale 1ns/1ps
`default_nettype none

module arithmeticUnit (
	input wire cpuPackage::word operandA,
	input wire cpuPackage::word operandB,
	input wire cpuPackage::aluOperation operation,
	output cpuPackage::word result,
	output logic zero
);

	logic lessThan;

	// slt compares as signed values
	assign lessThan = $signed(operandA) < $signed(operandB);

	always_comb begin
		case (operation)
			cpuPackage::aluSub: result = operandA - operandB;
			cpuPackage::aluAnd: result = operandA & operandB;
			cpuPackage::aluOr: result = operandA | operandB;
			cpuPackage::aluXor: result = operandA ^ operandB;
			cpuPackage::aluSlt: result = {31'd0, lessThan};
			default: result = operandA + operandB;
		endcase
	end

	// Drives the beq decision
	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- logic/pipelineCpu.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineCpu #(
	parameter cpuPackage::word resetAddress = '0
) (
	input wire clock,
	input wire reset,
	input wire cpuPackage::word instruction,
	input wire cpuPackage::word memoryReadData,
	output cpuPackage::word instructionAddress,
	output logic memoryWriteEnable,
	output cpuPackage::word memoryAddress,
	output cpuPackage::word memoryWriteData,
	output logic retireWriteEnable,
	output cpuPackage::registerIndex retireRegister,
	output cpuPackage::word retireData
);

	cpuPackage::word pc, nextPc, jumpTarget, branchTarget;
	logic stall, flushFetch, flushDecode, branchTaken;

	cpuPackage::word decodeInstruction, decodePc, decodeImmediate, decodeDataA, decodeDataB;
	cpuPackage::aluOperation decodeAluOp;
	cpuPackage::forwardSource forwardA, forwardB;
	logic decodeUseImmediate, decodeReadsSecond, decodeIsLoad, decodeIsStore;
	logic decodeIsBranch, decodeIsJump, decodeWrites;

	cpuPackage::word executePc, executeDataA, executeDataB, executeImmediate;
	cpuPackage::registerIndex executeDestination, executeTarget;
	cpuPackage::aluOperation executeAluOp;
	cpuPackage::forwardSource executeForwardA, executeForwardB;
	logic executeUseImmediate, executeIsLoad, executeIsStore, executeIsBranch;
	logic executeIsJump, executeWrites, aluZero;
	cpuPackage::word forwardedA, forwardedB, aluInputA, aluInputB, aluResult;

	cpuPackage::word memoryResult, memoryStoreData;
	cpuPackage::registerIndex memoryDestination;
	logic memoryIsLoad, memoryIsStore, memoryWrites;

	cpuPackage::word writebackData;
	cpuPackage::registerIndex writebackDestination;
	logic writebackWrites;

	// Fetch, with a taken beq ahead of a decoded jal
	assign instructionAddress = pc;
	assign nextPc = branchTaken ? branchTarget : decodeIsJump ? jumpTarget : pc + 32'd4;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= resetAddress;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			decodeInstruction <= cpuPackage::nopInstruction;
		end else if (flushFetch) begin
			decodeInstruction <= cpuPackage::nopInstruction;
		end else if (!stall) begin
			decodeInstruction <= instruction;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			decodePc <= pc;
		end
	end

	instructionDecoder decoder (
		.instruction(decodeInstruction),
		.aluOp(decodeAluOp),
		.immediate(decodeImmediate),
		.useImmediate(decodeUseImmediate),
		.readsSecond(decodeReadsSecond),
		.isLoad(decodeIsLoad),
		.isStore(decodeIsStore),
		.isBranch(decodeIsBranch),
		.isJump(decodeIsJump),
		.writesRegister(decodeWrites)
	);

	registerFile registerBank (
		.clock(clock),
		.reset(reset),
		.readIndexA(decodeInstruction[19:15]),
		.readIndexB(decodeInstruction[24:20]),
		.writeIndex(writebackDestination),
		.writeEnable(writebackWrites),
		.writeData(writebackData),
		.readDataA(decodeDataA),
		.readDataB(decodeDataB)
	);

	assign jumpTarget = decodePc + decodeImmediate;
	assign executeTarget = executeWrites ? executeDestination : 5'd0;

	hazardUnit hazards (
		.decodeSourceA(decodeInstruction[19:15]),
		.decodeSourceB(decodeInstruction[24:20]),
		.decodeReadsSecond(decodeReadsSecond),
		.decodeIsJump(decodeIsJump),
		.executeDestination(executeTarget),
		.executeIsLoad(executeIsLoad),
		.executeBranchTaken(branchTaken),
		.memoryDestination(memoryDestination),
		.memoryWrites(memoryWrites),
		.writebackDestination(writebackDestination),
		.writebackWrites(writebackWrites),
		.stall(stall),
		.flushFetch(flushFetch),
		.flushDecode(flushDecode),
		.forwardA(forwardA),
		.forwardB(forwardB)
	);

	// Decode/execute control, bubbled on a stall or a taken branch
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			executeIsLoad <= 1'b0;
			executeIsStore <= 1'b0;
			executeIsBranch <= 1'b0;
			executeIsJump <= 1'b0;
			executeWrites <= 1'b0;
		end else begin
			executeIsLoad <= decodeIsLoad && !flushDecode;
			executeIsStore <= decodeIsStore && !flushDecode;
			executeIsBranch <= decodeIsBranch && !flushDecode;
			executeIsJump <= decodeIsJump && !flushDecode;
			executeWrites <= decodeWrites && !flushDecode;
		end
	end

	always_ff @(posedge clock) begin
		executePc <= decodePc;
		executeDataA <= decodeDataA;
		executeDataB <= decodeDataB;
		executeImmediate <= decodeImmediate;
		executeDestination <= decodeInstruction[11:7];
		executeAluOp <= decodeAluOp;
		executeUseImmediate <= decodeUseImmediate;
		executeForwardA <= forwardA;
		executeForwardB <= forwardB;
	end

	function automatic cpuPackage::word forwardOperand(cpuPackage::forwardSource select,
		cpuPackage::word registerValue);
		case (select)
			cpuPackage::fromMemoryStage: return memoryResult;
			cpuPackage::fromWriteback: return writebackData;
			default: return registerValue;
		endcase
	endfunction

	always_comb begin
		forwardedA = forwardOperand(executeForwardA, executeDataA);
		forwardedB = forwardOperand(executeForwardB, executeDataB);
	end

	// jal computes its link value as PC plus 4
	assign aluInputA = executeIsJump ? executePc : forwardedA;
	assign aluInputB = executeIsJump ? 32'd4
		: executeUseImmediate ? executeImmediate : forwardedB;

	arithmeticUnit alu (
		.operandA(aluInputA),
		.operandB(aluInputB),
		.operation(executeAluOp),
		.result(aluResult),
		.zero(aluZero)
	);

	assign branchTarget = executePc + executeImmediate;
	assign branchTaken = executeIsBranch && aluZero;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			memoryIsLoad <= 1'b0;
			memoryIsStore <= 1'b0;
			memoryWrites <= 1'b0;
		end else begin
			memoryIsLoad <= executeIsLoad;
			memoryIsStore <= executeIsStore;
			memoryWrites <= executeWrites;
		end
	end

	always_ff @(posedge clock) begin
		memoryResult <= aluResult;
		memoryStoreData <= forwardedB;
		memoryDestination <= executeDestination;
	end

	assign memoryWriteEnable = memoryIsStore;
	assign memoryAddress = memoryResult;
	assign memoryWriteData = memoryStoreData;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			writebackWrites <= 1'b0;
		end else begin
			writebackWrites <= memoryWrites;
		end
	end

	// Load data picked here so writeback only holds the final value
	always_ff @(posedge clock) begin
		writebackData <= memoryIsLoad ? memoryReadData : memoryResult;
		writebackDestination <= memoryDestination;
	end

	assign retireWriteEnable = writebackWrites;
	assign retireRegister = writebackDestination;
	assign retireData = writebackData;

	// A store moves on to writeback without a register write
	assert property (@(posedge clock) disable iff (!reset)
		memoryWriteEnable |=> !retireWriteEnable)
		else $error("store also retired a register write");

endmodule

`default_nettype wire

//--- logic/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory #(
	parameter int dataWords = 64
) (
	input wire clock,
	input wire reset,
	input wire writeEnable,
	input wire cpuPackage::word address,
	input wire cpuPackage::word writeData,
	output cpuPackage::word readData
);

	localparam int indexBits = $clog2(dataWords);

	cpuPackage::word storage [dataWords];
	logic [indexBits-1:0] wordIndex;

	// Upper address bits wrap around the array
	assign wordIndex = address[indexBits+1:2];
	assign readData = storage[wordIndex];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < dataWords; i++) begin
				storage[i] <= '0;
			end
		end else if (writeEnable) begin
			storage[wordIndex] <= writeData;
		end
	end

	assert property (@(posedge clock) disable iff (!reset)
		writeEnable |-> address[1:0] == 2'b00)
		else $error("unaligned store to address %h", address);

endmodule

`default_nettype wire

//--- logic/cpuSystem.sv
`timescale 1ns/1ps
`default_nettype none

module cpuSystem #(
	parameter cpuPackage::word resetAddress = 32'h0000_0000,
	parameter int dataWords = 64
) (
	input wire clock,
	input wire reset,
	input wire cpuPackage::word instruction,
	output wire cpuPackage::word instructionAddress,
	output wire memoryWriteEnable,
	output wire cpuPackage::word memoryAddress,
	output wire cpuPackage::word memoryWriteData,
	output wire retireWriteEnable,
	output wire cpuPackage::registerIndex retireRegister,
	output wire cpuPackage::word retireData
);

	cpuPackage::word memoryReadData;

	pipelineCpu #(
		.resetAddress(resetAddress)
	) cpu (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.memoryReadData(memoryReadData),
		.instructionAddress(instructionAddress),
		.memoryWriteEnable(memoryWriteEnable),
		.memoryAddress(memoryAddress),
		.memoryWriteData(memoryWriteData),
		.retireWriteEnable(retireWriteEnable),
		.retireRegister(retireRegister),
		.retireData(retireData)
	);

	dataMemory #(
		.dataWords(dataWords)
	) memory (
		.clock(clock),
		.reset(reset),
		.writeEnable(memoryWriteEnable),
		.address(memoryAddress),
		.writeData(memoryWriteData),
		.readData(memoryReadData)
	);

endmodule

`default_nettype wire

//--- verification/isaModel.svh
`ifndef isaModelSvh
`define isaModelSvh

// Architectural state of the in-order reference model
cpuPackage::word modelRegisters [32];
cpuPackage::word modelMemory [64];

// Expected results, oldest first
cpuPackage::registerIndex expectedRegisters [$];
cpuPackage::word expectedValues [$];
cpuPackage::word expectedAddresses [$];
cpuPackage::word expectedStoreData [$];

function automatic cpuPackage::word modelAlu(logic [2:0] funct3, logic subtract,
	cpuPackage::word a, cpuPackage::word b);
	case (funct3)
		3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b100: return a ^ b;
		3'b110: return a | b;
		3'b111: return a & b;
		default: return subtract ? a - b : a + b;
	endcase
endfunction

// x0 ignores writes
task automatic recordWrite(cpuPackage::registerIndex destination, cpuPackage::word value);
	if (destination != 5'd0) begin
		modelRegisters[destination] = value;
		expectedRegisters.push_back(destination);
		expectedValues.push_back(value);
	end
endtask

task automatic runModel();
	cpuPackage::word pc, nextPc, current, a, b, address;
	cpuPackage::word immI, immS, immB, immJ;
	cpuPackage::registerIndex rd, rs1, rs2;
	logic [2:0] funct3;
	for (int i = 0; i < 32; i++) begin
		modelRegisters[i] = '0;
	end
	for (int i = 0; i < 64; i++) begin
		modelMemory[i] = '0;
	end
	pc = '0;
	// Offsets only go forward, so the walk always ends
	while (pc < programBytes) begin
		current = programWords[pc[9:2]];
		rd = current[11:7];
		rs1 = current[19:15];
		rs2 = current[24:20];
		funct3 = current[14:12];
		immI = {{20{current[31]}}, current[31:20]};
		immS = {{20{current[31]}}, current[31:25], current[11:7]};
		immB = {{20{current[31]}}, current[7], current[30:25], current[11:8], 1'b0};
		immJ = {{12{current[31]}}, current[19:12], current[20], current[30:21], 1'b0};
		a = modelRegisters[rs1];
		b = modelRegisters[rs2];
		nextPc = pc + 32'd4;
		case (current[6:0])
			cpuPackage::opRegister: recordWrite(rd, modelAlu(funct3, current[30], a, b));
			cpuPackage::opImmediate: recordWrite(rd, modelAlu(funct3, 1'b0, a, immI));
			cpuPackage::opLoad: begin
				address = a + immI;
				recordWrite(rd, modelMemory[address[7:2]]);
			end
			cpuPackage::opStore: begin
				address = a + immS;
				modelMemory[address[7:2]] = b;
				expectedAddresses.push_back(address);
				expectedStoreData.push_back(b);
			end
			cpuPackage::opBranch: begin
				if (a == b) begin
					nextPc = pc + immB;
				end
			end
			cpuPackage::opJump: begin
				recordWrite(rd, pc + 32'd4);
				nextPc = pc + immJ;
			end
			default: begin
			end
		endcase
		pc = nextPc;
	end
endtask

`endif

//--- verification/cpuSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuSystemTb;

	localparam int programLength = 200;
	localparam int cycleLimit = 4 * programLength + 50;
	localparam cpuPackage::word programBytes = 32'(programLength * 4);

	logic clock;
	logic reset;
	cpuPackage::word instruction;
	cpuPackage::word instructionAddress;
	logic memoryWriteEnable;
	cpuPackage::word memoryAddress;
	cpuPackage::word memoryWriteData;
	logic retireWriteEnable;
	cpuPackage::registerIndex retireRegister;
	cpuPackage::word retireData;

	integer seed;
	int cycleCount;
	int idleCycles;
	cpuPackage::word programWords [256];

	`include "isaModel.svh"

	cpuSystem dut (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.instructionAddress(instructionAddress),
		.memoryWriteEnable(memoryWriteEnable),
		.memoryAddress(memoryAddress),
		.memoryWriteData(memoryWriteData),
		.retireWriteEnable(retireWriteEnable),
		.retireRegister(retireRegister),
		.retireData(retireData)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic stopWithFailure();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic reportProblem(string text);
		$display("%s", text);
		stopWithFailure();
	endtask

	task automatic reportMismatch(string signalName, cpuPackage::word expected,
		cpuPackage::word actual);
		$display("FAIL time %0t %s expected %h actual %h", $time, signalName, expected, actual);
		stopWithFailure();
	endtask

	task automatic compareRetire(cpuPackage::registerIndex actualRegister,
		cpuPackage::word actualData);
		cpuPackage::registerIndex expectedRegister;
		cpuPackage::word expectedData;
		if (actualRegister == 5'd0) begin
			reportProblem($sformatf("register write to x0 at time %0t", $time));
		end else if (expectedRegisters.size() == 0) begin
			reportProblem($sformatf("unexpected write to x%0d at time %0t",
				actualRegister, $time));
		end else begin
			expectedRegister = expectedRegisters.pop_front();
			expectedData = expectedValues.pop_front();
			if (actualRegister != expectedRegister) begin
				reportMismatch("retireRegister", 32'(expectedRegister), 32'(actualRegister));
			end else if (actualData != expectedData) begin
				reportMismatch("retireData", expectedData, actualData);
			end
		end
	endtask

	task automatic compareStore(cpuPackage::word actualAddress, cpuPackage::word actualData);
		cpuPackage::word expectedAddress;
		cpuPackage::word expectedData;
		if (expectedAddresses.size() == 0) begin
			reportProblem($sformatf("unexpected store to %h at time %0t", actualAddress, $time));
		end else begin
			expectedAddress = expectedAddresses.pop_front();
			expectedData = expectedStoreData.pop_front();
			if (actualAddress != expectedAddress) begin
				reportMismatch("memoryAddress", expectedAddress, actualAddress);
			end else if (actualData != expectedData) begin
				reportMismatch("memoryWriteData", expectedData, actualData);
			end
		end
	endtask

	function automatic cpuPackage::registerIndex pickRegister();
		return 5'(1 + $unsigned($random(seed)) % 7);
	endfunction

	// Kinds 0 to 5 are add, sub, and, or, xor, slt
	function automatic cpuPackage::word encodeRegister(int kind, cpuPackage::registerIndex rs2,
		cpuPackage::registerIndex rs1, cpuPackage::registerIndex rd);
		logic [6:0] funct7;
		logic [2:0] funct3;
		funct7 = (kind == 1) ? 7'b0100000 : 7'b0000000;
		case (kind)
			2: funct3 = 3'b111;
			3: funct3 = 3'b110;
			4: funct3 = 3'b100;
			5: funct3 = 3'b010;
			default: funct3 = 3'b000;
		endcase
		return {funct7, rs2, rs1, funct3, rd, cpuPackage::opRegister};
	endfunction

	task automatic generateProgram();
		cpuPackage::word randomValue;
		cpuPackage::registerIndex rd, rs1, rs2;
		logic [11:0] offset;
		logic [12:0] branchOffset;
		logic [20:0] jumpOffset;
		int kind;
		int skip;
		for (int i = 0; i < 256; i++) begin
			programWords[i] = cpuPackage::nopInstruction;
		end
		for (int i = 0; i < programLength; i++) begin
			kind = int'($unsigned($random(seed)) % 16);
			rd = pickRegister();
			rs1 = pickRegister();
			rs2 = pickRegister();
			randomValue = $random(seed);
			skip = 2 + int'($unsigned($random(seed)) % 3);
			offset = {4'd0, randomValue[7:2], 2'b00};
			branchOffset = 13'(skip * 4);
			jumpOffset = 21'(skip * 4);
			// Keep jump targets inside the program
			if ((kind == 13 || kind == 14) && i + 4 >= programLength) begin
				kind = 6;
			end
			case (kind)
				0, 1, 2, 3, 4, 5: programWords[i] = encodeRegister(kind, rs2, rs1, rd);
				9, 10: programWords[i] = {offset, 5'd0, 3'b010, rd, cpuPackage::opLoad};
				11, 12: programWords[i] = {offset[11:5], rs2, 5'd0, 3'b010, offset[4:0],
					cpuPackage::opStore};
				13: begin
					// Equal sources half the time so branches get taken
					if (randomValue[31]) begin
						rs2 = rs1;
					end
					programWords[i] = {branchOffset[12], branchOffset[10:5], rs2, rs1, 3'b000,
						branchOffset[4:1], branchOffset[11], cpuPackage::opBranch};
				end
				14: programWords[i] = {jumpOffset[20], jumpOffset[10:1], jumpOffset[11],
					jumpOffset[19:12], rd, cpuPackage::opJump};
				default: programWords[i] = {randomValue[11:0], rs1, 3'b000, rd,
					cpuPackage::opImmediate};
			endcase
		end
	endtask

	task automatic driveInstruction();
		if (instructionAddress < programBytes) begin
			instruction = programWords[instructionAddress[9:2]];
		end else begin
			instruction = cpuPackage::nopInstruction;
		end
	endtask

	task automatic checkResults();
		if (retireWriteEnable) begin
			compareRetire(retireRegister, retireData);
		end
		if (memoryWriteEnable) begin
			compareStore(memoryAddress, memoryWriteData);
		end
	endtask

	initial begin
		reset = 1'b1;
		instruction = cpuPackage::nopInstruction;
		seed = 32'h43ad;
		cycleCount = 0;
		idleCycles = 0;
		generateProgram();
		runModel();
		// A real falling edge so the asynchronous reset fires
		#1 reset = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		if (memoryWriteEnable || retireWriteEnable) begin
			reportProblem("a write enable was high while reset was held");
		end
		if (instructionAddress != 32'h0000_0000) begin
			reportMismatch("instructionAddress", 32'h0000_0000, instructionAddress);
		end
		driveInstruction();
		reset = 1'b1;
		while (idleCycles < 8 && cycleCount < cycleLimit) begin
			@(negedge clock);
			cycleCount++;
			checkResults();
			driveInstruction();
			if (expectedRegisters.size() == 0 && expectedAddresses.size() == 0
				&& instructionAddress >= programBytes) begin
				idleCycles++;
			end else begin
				idleCycles = 0;
			end
		end
		if (expectedRegisters.size() == 0 && expectedAddresses.size() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			reportProblem($sformatf(
				"timeout after %0d cycles, %0d register writes and %0d stores missing",
				cycleCount, expectedRegisters.size(), expectedAddresses.size()));
		end
	end

endmodule

`default_nettype wire

//--- cpuSystem.f
+incdir+verification
logic/cpuPackage.sv
logic/instructionDecoder.sv
logic/registerFile.sv
logic/hazardUnit.sv
logic/arithmeticUnit.sv
logic/pipelineCpu.sv
logic/dataMemory.sv
logic/cpuSystem.sv
verification/cpuSystemTb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpuSystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

mkdir -p build
if ! verilator --binary --timing --timescale 1ns/1ps --top-module cpuSystemTb \
	-Mdir build -f cpuSystem.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./build/VcpuSystemTb > build/simulation.log 2>&1; then
	cat build/simulation.log
	echo "Simulation exited with an error"
	exit 1
fi
cat build/simulation.log

if grep -q "ALL TESTS PASSED" build/simulation.log; then
	exit 0
fi
exit 1
